// File: Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - .
    files:
      - verilog/cachePkg.sv
      - verilog/cacheFsm.sv
      - verilog/cacheWay.sv
      - verilog/wayMerge.sv
      - verilog/cacheTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - test/cacheClock.sv
      - test/cache_properties.sv
      - test/cacheTb.sv

// File: cache_settings.svh
// Cache geometry macros; set count and words per line must be powers of two and LRU expects 2 ways
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Geometry
////////////////////////////////////////////////////////////////////////////

// Number of sets, indexed by the low address bits above the offset
`define CACHE_SETS 8

`define CACHE_WAYS 2  // Associativity, LRU bit per set covers 2 ways only

`define LINE_WORDS 4  // Words per line, one bus beat moves a full line

////////////////////////////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////////////////////////////

`define WORD_BITS 32  // Data word

// Word address, so tag = ADR_BITS - set bits - offset bits
`define ADR_BITS 12

`endif

// File: test/cacheClock.sv
// Free-running clock and active-low reset, released on a falling edge after resetCycles rising edges
module cacheClock #(
  parameter int period      = 40,
  parameter int resetCycles = 5
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    arstN = 1'b0;  // Held from time zero
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;  // Away from the active edge
  end

endmodule

// File: test/cacheTb.sv
// Cache testbench; memory model serves one line request at a time and fill words assume 12-bit addresses
`include "cache_settings.svh"

module cacheTb;

  localparam int period       = 40;
  localparam int requestCount = 300;  // Watchdog budget
  localparam int cyclesPerReq = 40;
  localparam int randomOps    = 200;
  localparam int testSpan     = 256;  // 64 lines of 4 words
  localparam int lineCount    = 1 << (`ADR_BITS - cachePkg::offsetBits);
  localparam cachePkg::adrT testBase = 12'h400;

  logic             clk;
  logic             arstN;
  logic [1:0]       cacheRW;
  cachePkg::adrT    adr;
  cachePkg::wordT   writeData;
  logic             flushCache;
  logic             invalidateCache;
  logic             busAck;
  cachePkg::lineT   readLine;
  cachePkg::wordT   readData;
  logic             cacheStall;
  cachePkg::busReqT busReq;

  cachePkg::lineT memory [lineCount];      // Memory model lines
  cachePkg::wordT shadow [1 << `ADR_BITS]; // What the core wrote
  logic [15:0]    lfsrState = 16'd48;
  int             busReads  = 0;

  cacheClock #(.period(period), .resetCycles(5)) clockGen (.clk, .arstN);

  cacheTop DUT (
    .clk, .arstN, .cacheRW, .adr, .writeData, .flushCache, .invalidateCache,
    .busAck, .readLine, .readData, .cacheStall, .busReq
  );

  bind cacheTop cacheProperties props (
    .clk, .arstN, .cacheRW, .flushCache, .invalidateCache, .busAck, .cacheStall,
    .hit, .busReq, .wayCtl, .state(fsm.state)
  );

  // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
  function automatic logic [31:0] lfsrBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], feedback};
      value     = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic cachePkg::wordT fillWord(input cachePkg::adrT a);
    return cachePkg::wordT'({a, ~a, 8'h5A});  // Whole address in every word
  endfunction

  task automatic stopRun();
    $display("Something failed");
    $fatal(1);
  endtask

  // Called at a falling edge, returns at the sample point of the stall-free cycle
  task automatic access(input string testName, input logic doWrite,
                        input cachePkg::adrT a, input cachePkg::wordT data);
    cacheRW   = doWrite ? 2'b01 : 2'b10;
    adr       = a;
    writeData = data;
    #(period / 4);  // Ack and inputs settled
    while (cacheStall) begin
      @(negedge clk);
      #(period / 4);
    end
    if (doWrite) begin
      shadow[a] = data;  // Stored at the coming edge
    end else begin
      assert (readData == shadow[a]) else begin
        $display("[ERROR] %s adr %h: expected %h, actual %h", testName, a, shadow[a], readData);
        stopRun();
      end
    end
  endtask

  task automatic flushAll();
    @(negedge clk);
    cacheRW    = 2'b00;
    flushCache = 1'b1;
    #(period / 4);
    while (cacheStall) begin
      @(negedge clk);
      #(period / 4);
    end
    @(negedge clk);
    flushCache = 1'b0;
  endtask

  task automatic compareMemory(input string testName);
    cachePkg::adrT  a;
    cachePkg::wordT stored;
    for (int i = 0; i < testSpan; i++) begin
      a      = testBase | cachePkg::adrT'(i);
      stored = memory[a >> cachePkg::offsetBits][a[cachePkg::offsetBits-1:0]*`WORD_BITS +: `WORD_BITS];
      assert (stored == shadow[a]) else begin
        $display("[ERROR] %s adr %h: expected %h, actual %h", testName, a, shadow[a], stored);
        stopRun();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, ack after 1 to 4 cycles
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memoryModel
    cachePkg::busReqT req;
    int               lineIdx;
    busAck   = 1'b0;
    readLine = '0;
    forever begin
      @(negedge clk);
      busAck = 1'b0;
      #(period / 4);
      if (busReq.read || busReq.write) begin
        req     = busReq;
        lineIdx = req.adr >> cachePkg::offsetBits;
        repeat (1 + lfsrBits(2)) @(negedge clk);
        if (req.write) begin
          memory[lineIdx] = req.writeLine;
        end else begin
          readLine = memory[lineIdx];
          busReads++;
        end
        busAck = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    cachePkg::adrT  a;
    cachePkg::adrT  lastAdr;
    cachePkg::wordT data;
    logic           doWrite;
    int             readsBefore;
    cacheRW         = 2'b00;
    adr             = '0;
    writeData       = '0;
    flushCache      = 1'b0;
    invalidateCache = 1'b0;
    for (int i = 0; i < (1 << `ADR_BITS); i++) begin
      shadow[i] = fillWord(cachePkg::adrT'(i));
      memory[i >> cachePkg::offsetBits][(i % `LINE_WORDS)*`WORD_BITS +: `WORD_BITS] =
        fillWord(cachePkg::adrT'(i));
    end
    @(posedge arstN);
    // Random mix over 64 lines, four times the capacity
    for (int n = 0; n < randomOps; n++) begin
      @(negedge clk);
      if (lfsrBits(2) == 0) begin  // Idle cycle now and then
        cacheRW = 2'b00;
        @(negedge clk);
      end
      doWrite = 1'(lfsrBits(1));
      a       = testBase | cachePkg::adrT'(lfsrBits(8));
      data    = lfsrBits(32);
      access("randomAccess", doWrite, a, data);
      lastAdr = a;
    end
    flushAll();
    compareMemory("flushCompare");
    @(negedge clk);
    invalidateCache = 1'b1;  // One cycle in ready
    @(negedge clk);
    invalidateCache = 1'b0;
    readsBefore     = busReads;
    @(negedge clk);
    access("readAfterInvalidate", 1'b0, lastAdr, '0);
    assert (busReads > readsBefore) else begin
      $display("Read after invalidate was served without a bus read");
      stopRun();
    end
    @(negedge clk);
    cacheRW = 2'b00;
    repeat (2) @(negedge clk);
    if (DUT.props.errCount == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("A protocol assertion failed during the run");
      stopRun();
    end
  end

  // Stop at the first failed protocol assertion
  always @(negedge clk) begin
    if (DUT.props.errCount != 0) begin
      $display("A bus or controller protocol assertion failed");
      stopRun();
    end
  end

  initial begin : watchdog
    #(requestCount * cyclesPerReq * period);
    $display("Watchdog expired, the cache stopped making progress");
    stopRun();
  end

endmodule

// File: test/cache_properties.sv
// Bus and controller checks for cacheTop; bound into it, so the FSM state is reached as fsm.state
module cacheProperties (
  input logic                 clk,
  input logic                 arstN,
  input logic [1:0]           cacheRW,
  input logic                 flushCache,
  input logic                 invalidateCache,
  input logic                 busAck,
  input logic                 cacheStall,
  input logic                 hit,
  input cachePkg::busReqT     busReq,
  input cachePkg::wayCtlT     wayCtl,
  input cachePkg::cacheStateT state
);

  int   errCount = 0;  // Watched from the testbench
  logic idle;
  logic strobes;       // Any way update

  assign idle = (state == cachePkg::stReady) & (cacheRW == 2'b00) & ~flushCache & ~invalidateCache;
  assign strobes = wayCtl.setValid | wayCtl.clearValid | wayCtl.setDirty | wayCtl.clearDirty
                 | wayCtl.writeWord | wayCtl.writeLine;

  ////////////////////////////////////////////////////////////////////////////
  // Reset and idle
  ////////////////////////////////////////////////////////////////////////////

  resetQuiet: assert property (@(posedge clk)
    !arstN |-> (state == cachePkg::stReady) && !busReq.read && !busReq.write && !strobes)
    else begin $error("Bus request or strobe active in reset"); errCount++; end

  idleQuiet: assert property (@(posedge clk) disable iff (!arstN)
    idle |-> !busReq.read && !busReq.write && !cacheStall && !strobes)
    else begin $error("Idle cache stalls or drives the bus"); errCount++; end

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////////////////////////////////////////

  oneDirection: assert property (@(posedge clk) disable iff (!arstN)
    !(busReq.read && busReq.write))
    else begin $error("Bus read and write high together"); errCount++; end

  // Request gone in the ack cycle
  dropAtAck: assert property (@(posedge clk) disable iff (!arstN)
    busAck |-> !busReq.read && !busReq.write)
    else begin $error("Bus request still high at ack"); errCount++; end

  holdUntilAck: assert property (@(posedge clk) disable iff (!arstN)
    (busReq.read || busReq.write) && !busAck |=> busAck
      || ($stable(busReq.read) && $stable(busReq.write) && $stable(busReq.adr)
          && (!busReq.write || $stable(busReq.writeLine))))
    else begin $error("Bus request changed before ack"); errCount++; end

  fetchAfterWriteback: assert property (@(posedge clk) disable iff (!arstN)
    (state == cachePkg::stWriteback) && busAck |=> busReq.read)
    else begin $error("No fetch after victim writeback"); errCount++; end

  readOnlyOnMiss: assert property (@(posedge clk) disable iff (!arstN)
    busReq.read |-> !hit && (cacheRW != 2'b00))
    else begin $error("Bus read without a core miss"); errCount++; end

endmodule

// File: verilog.f
+incdir+.
verilog/cachePkg.sv
verilog/cacheFsm.sv
verilog/cacheWay.sv
verilog/wayMerge.sv
verilog/cacheTop.sv
test/cacheClock.sv
test/cache_properties.sv
test/cacheTb.sv

// File: verilog/cacheFsm.sv
// Cache controller; no CMO, stall or pipeline flush inputs, and readLine is sampled only on busAck in fetch
`include "cache_settings.svh"

module cacheFsm (
  input  logic               clk,
  input  logic               arstN,
  input  logic [1:0]         cacheRW,          // [1] read, [0] write
  input  cachePkg::adrT      adr,
  input  cachePkg::wordT     writeData,
  input  logic               flushCache,       // Level until stall drops
  input  logic               invalidateCache,  // Pulse in ready
  input  logic               busAck,
  input  cachePkg::lineT     readLine,
  input  logic               hit,
  input  logic               victimDirty,
  input  logic               dirtyAtFlush,
  output logic               cacheStall,
  output logic               busRead,
  output logic               busWrite,
  output logic               busFromFlush,     // Bus address from flush counters
  output cachePkg::setIdxT   flushSet,
  output cachePkg::wayCtlT   wayCtl,
  output logic               lruUpdate
);

  cachePkg::cacheStateT state, nextState;
  cachePkg::wayIdxT     flushWayCnt;
  cachePkg::lineT       fetchLine;   // Line captured at fetch ack
  cachePkg::lineT       mergedLine;
  cachePkg::setIdxT     reqSet;
  cachePkg::offsetT     reqOffset;
  logic                 anyMiss;
  logic                 readyHit;
  logic                 readyMiss;
  logic                 flushLast;
  logic                 flushStep;

  // Request address fields
  assign reqOffset = adr[cachePkg::offsetBits-1:0];
  assign reqSet    = adr[cachePkg::offsetBits +: cachePkg::setBits];

  assign anyMiss   = (|cacheRW) & ~hit & ~invalidateCache;
  assign readyHit  = (state == cachePkg::stReady) & (|cacheRW) & hit
                     & ~flushCache & ~invalidateCache;
  assign readyMiss = (state == cachePkg::stReady) & anyMiss & ~flushCache;

  ////////////////////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= cachePkg::stReady;
    else        state <= nextState;
  end

  always_comb begin
    nextState = state;  // Hold by default
    case (state)
      cachePkg::stReady: begin
        if (invalidateCache)          nextState = cachePkg::stReady;    // One cycle, no writeback
        else if (flushCache)          nextState = cachePkg::stFlush;
        else if (anyMiss & ~victimDirty) nextState = cachePkg::stFetch;
        else if (anyMiss)             nextState = cachePkg::stWriteback;
      end
      cachePkg::stFetch:     if (busAck) nextState = cachePkg::stWriteLine;
      cachePkg::stWriteback: if (busAck) nextState = cachePkg::stFetch;  // Read rises next cycle
      cachePkg::stWriteLine: nextState = cachePkg::stReadHold;
      cachePkg::stReadHold:  nextState = cachePkg::stReady;
      cachePkg::stFlush: begin
        if (dirtyAtFlush)   nextState = cachePkg::stFlushWriteback;
        else if (flushLast) nextState = cachePkg::stReadHold;
      end
      cachePkg::stFlushWriteback: begin
        if (busAck & flushLast) nextState = cachePkg::stReadHold;
        else if (busAck)        nextState = cachePkg::stFlush;
      end
      default: nextState = cachePkg::stReady;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flush set and way counters
  ////////////////////////////////////////////////////////////////////////////

  // Clean line steps at once, dirty line steps at its writeback ack
  assign flushStep = ((state == cachePkg::stFlush) & ~dirtyAtFlush)
                   | ((state == cachePkg::stFlushWriteback) & busAck);
  assign flushLast = (flushSet == cachePkg::setIdxT'(`CACHE_SETS - 1))
                   & (flushWayCnt == cachePkg::wayIdxT'(`CACHE_WAYS - 1));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flushSet    <= '0;
      flushWayCnt <= '0;
    end else if (flushStep) begin
      if (flushLast) begin  // Back to zero for the next flush
        flushSet    <= '0;
        flushWayCnt <= '0;
      end else if (flushWayCnt == cachePkg::wayIdxT'(`CACHE_WAYS - 1)) begin
        flushWayCnt <= '0;
        flushSet    <= flushSet + 1'b1;
      end else begin
        flushWayCnt <= flushWayCnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetched line and write merge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if ((state == cachePkg::stFetch) && busAck) fetchLine <= readLine;
  end

  // Pending store word lands in the fetched line
  always_comb begin
    mergedLine = fetchLine;
    if (cacheRW[0]) mergedLine[reqOffset*`WORD_BITS +: `WORD_BITS] = writeData;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Way strobes, bus and core outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wayCtl.setIdx        = busFromFlush ? flushSet : reqSet;
    wayCtl.offset        = reqOffset;
    wayCtl.selWay        = (state == cachePkg::stWriteback) | (state == cachePkg::stWriteLine);
    wayCtl.useFlushWay   = busFromFlush;
    wayCtl.flushWay      = flushWayCnt;
    wayCtl.writeWord     = readyHit & cacheRW[0];  // Store hit
    wayCtl.wordData      = writeData;
    wayCtl.writeLine     = state == cachePkg::stWriteLine;
    wayCtl.lineData      = mergedLine;
    wayCtl.setValid      = state == cachePkg::stWriteLine;
    // Victim is gone from the cache once memory holds it
    wayCtl.clearValid    = (state == cachePkg::stWriteback) & busAck;
    wayCtl.setDirty      = (readyHit | (state == cachePkg::stWriteLine)) & cacheRW[0];
    wayCtl.clearDirty    = ((state == cachePkg::stWriteLine) & ~cacheRW[0])
                         | ((state == cachePkg::stFlushWriteback) & busAck);
    wayCtl.invalidateAll = (state == cachePkg::stReady) & invalidateCache;
  end

  assign lruUpdate    = readyHit | (state == cachePkg::stWriteLine);
  assign busFromFlush = (state == cachePkg::stFlush) | (state == cachePkg::stFlushWriteback);

  // Requests drop in the ack cycle
  assign busRead  = (readyMiss & ~victimDirty)
                  | ((state == cachePkg::stFetch) & ~busAck);
  assign busWrite = (readyMiss & victimDirty)
                  | ((state == cachePkg::stWriteback) & ~busAck)
                  | ((state == cachePkg::stFlushWriteback) & ~busAck);

  // Read hold and idle ready are the only stall-free states
  assign cacheStall = ((state == cachePkg::stReady) & (flushCache | anyMiss))
                    | (state == cachePkg::stFetch)
                    | (state == cachePkg::stWriteback)
                    | (state == cachePkg::stWriteLine)
                    | (state == cachePkg::stFlush)
                    | (state == cachePkg::stFlushWriteback);

endmodule

// File: verilog/cachePkg.sv
// Cache types; all widths derive from cache_settings.svh, which must be on the include path
`include "cache_settings.svh"

package cachePkg;

  // Derived widths
  localparam int setBits    = $clog2(`CACHE_SETS);
  localparam int offsetBits = $clog2(`LINE_WORDS);
  localparam int wayBits    = (`CACHE_WAYS > 1) ? $clog2(`CACHE_WAYS) : 1;
  localparam int tagBits    = `ADR_BITS - setBits - offsetBits;
  localparam int lineBits   = `LINE_WORDS * `WORD_BITS;

  typedef logic [`WORD_BITS-1:0] wordT;    // One data word
  typedef logic [lineBits-1:0]   lineT;    // Word 0 in the low bits
  typedef logic [tagBits-1:0]    tagT;
  typedef logic [setBits-1:0]    setIdxT;
  typedef logic [offsetBits-1:0] offsetT;  // Word within line
  typedef logic [wayBits-1:0]    wayIdxT;
  typedef logic [`ADR_BITS-1:0]  adrT;     // {tag, set, offset}

  // Controller states
  typedef enum logic [2:0] {
    stReady,           // Hits served here
    stFetch,           // Line read on the bus
    stWriteback,       // Dirty victim out before fetch
    stWriteLine,       // Fetched line stored
    stReadHold,        // Stall low, read data from new line
    stFlush,           // Walk sets and ways
    stFlushWriteback   // Dirty line out during flush
  } cacheStateT;

  // Controller to every way
  typedef struct packed {
    setIdxT setIdx;
    offsetT offset;
    logic   selWay;         // Victim way instead of hit way
    logic   useFlushWay;    // Flush counter way overrides both
    wayIdxT flushWay;
    logic   writeWord;
    wordT   wordData;
    logic   writeLine;      // Also loads the tag
    lineT   lineData;
    logic   setValid;
    logic   clearValid;
    logic   setDirty;
    logic   clearDirty;
    logic   invalidateAll;  // All sets, all ways
  } wayCtlT;

  // Each way to the merge block, for the addressed set
  typedef struct packed {
    logic hit;
    logic valid;
    logic dirty;
    tagT  tag;
    lineT line;
  } wayStatusT;

  // Line bus request, held until ack
  typedef struct packed {
    logic read;
    logic write;
    adrT  adr;        // Line address, offset bits zero
    lineT writeLine;
  } busReqT;

endpackage

// File: verilog/cacheTop.sv
// Cache top level; the core holds its request until cacheStall is low and memory acks each line once
`include "cache_settings.svh"

module cacheTop (
  input  logic               clk,
  input  logic               arstN,
  input  logic [1:0]         cacheRW,
  input  cachePkg::adrT      adr,
  input  cachePkg::wordT     writeData,
  input  logic               flushCache,
  input  logic               invalidateCache,
  input  logic               busAck,
  input  cachePkg::lineT     readLine,
  output cachePkg::wordT     readData,
  output logic               cacheStall,
  output cachePkg::busReqT   busReq
);

  cachePkg::wayCtlT    wayCtl;
  cachePkg::wayStatusT wayStatus [`CACHE_WAYS];
  cachePkg::tagT       reqTag;
  cachePkg::setIdxT    reqSet;
  cachePkg::setIdxT    flushSet;
  cachePkg::wayIdxT    victimWay;
  cachePkg::tagT       victimTag;
  cachePkg::lineT      victimLine;
  logic                hit;
  logic                victimDirty;
  logic                dirtyAtFlush;
  logic                lruUpdate;
  logic                busRead;
  logic                busWrite;
  logic                busFromFlush;

  assign reqTag = adr[`ADR_BITS-1 -: cachePkg::tagBits];
  assign reqSet = adr[cachePkg::offsetBits +: cachePkg::setBits];

  cacheFsm fsm (
    .clk, .arstN, .cacheRW, .adr, .writeData, .flushCache, .invalidateCache,
    .busAck, .readLine, .hit, .victimDirty, .dirtyAtFlush,
    .cacheStall, .busRead, .busWrite, .busFromFlush, .flushSet, .wayCtl, .lruUpdate
  );

  // All ways get the same controls
  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gWay
    cacheWay #(.wayNum(w)) way (
      .clk, .arstN, .wayCtl, .lookupTag(reqTag), .victimWay, .wayStatus(wayStatus[w])
    );
  end

  wayMerge merge (
    .clk, .arstN, .wayStatus, .setIdx(wayCtl.setIdx), .offset(wayCtl.offset), .lruUpdate,
    .hit, .hitWay(), .victimWay, .victimDirty, .victimTag, .victimLine, .readData,
    .dirtyAtFlush
  );

  // Line address: flush walk, victim writeback, or request fetch
  always_comb begin
    busReq.read      = busRead;
    busReq.write     = busWrite;
    busReq.writeLine = victimLine;
    if (busFromFlush)  busReq.adr = {victimTag, flushSet, cachePkg::offsetT'(0)};
    else if (busWrite) busReq.adr = {victimTag, reqSet, cachePkg::offsetT'(0)};
    else               busReq.adr = {reqTag, reqSet, cachePkg::offsetT'(0)};
  end

endmodule

// File: verilog/cacheWay.sv
// One cache way for all sets in flops; during a flush, hit means this is the flush counter's way
`include "cache_settings.svh"

module cacheWay #(
  parameter int wayNum = 0  // Index of this way
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  cachePkg::wayCtlT     wayCtl,
  input  cachePkg::tagT        lookupTag,
  input  cachePkg::wayIdxT     victimWay,
  output cachePkg::wayStatusT  wayStatus
);

  cachePkg::tagT          tagMem  [`CACHE_SETS];
  cachePkg::lineT         lineMem [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] validBits;
  logic [`CACHE_SETS-1:0] dirtyBits;
  logic                   tagHit;
  logic                   flushSel;
  logic                   victimSel;
  logic                   selected;   // This way takes the strobes

  assign tagHit    = validBits[wayCtl.setIdx] & (tagMem[wayCtl.setIdx] == lookupTag);
  assign flushSel  = wayCtl.flushWay == cachePkg::wayIdxT'(wayNum);
  assign victimSel = victimWay == cachePkg::wayIdxT'(wayNum);

  // Flush way, else victim way, else hit way
  assign selected = wayCtl.useFlushWay ? flushSel
                  : wayCtl.selWay      ? victimSel
                  : tagHit;

  ////////////////////////////////////////////////////////////////////////////
  // Status for the addressed set
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wayStatus.hit   = wayCtl.useFlushWay ? flushSel : tagHit;
    wayStatus.valid = validBits[wayCtl.setIdx];
    wayStatus.dirty = dirtyBits[wayCtl.setIdx];
    wayStatus.tag   = tagMem[wayCtl.setIdx];
    wayStatus.line  = lineMem[wayCtl.setIdx];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and dirty bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (wayCtl.invalidateAll) begin
        validBits <= '0;  // Dirty bits stay, valid masks them
      end else if (selected) begin
        if (wayCtl.setValid)        validBits[wayCtl.setIdx] <= 1'b1;
        else if (wayCtl.clearValid) validBits[wayCtl.setIdx] <= 1'b0;
      end
      if (selected) begin
        if (wayCtl.setDirty)        dirtyBits[wayCtl.setIdx] <= 1'b1;
        else if (wayCtl.clearDirty) dirtyBits[wayCtl.setIdx] <= 1'b0;
      end
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (selected && wayCtl.writeLine) begin
      lineMem[wayCtl.setIdx] <= wayCtl.lineData;  // Store already merged in
      tagMem[wayCtl.setIdx]  <= lookupTag;
    end else if (selected && wayCtl.writeWord) begin
      lineMem[wayCtl.setIdx][wayCtl.offset*`WORD_BITS +: `WORD_BITS] <= wayCtl.wordData;
    end
  end

endmodule

// File: verilog/wayMerge.sv
// Merges way status into one result; the LRU update assumes exactly 2 ways
`include "cache_settings.svh"

module wayMerge (
  input  logic                 clk,
  input  logic                 arstN,
  input  cachePkg::wayStatusT  wayStatus [`CACHE_WAYS],
  input  cachePkg::setIdxT     setIdx,
  input  cachePkg::offsetT     offset,
  input  logic                 lruUpdate,
  output logic                 hit,
  output cachePkg::wayIdxT     hitWay,
  output cachePkg::wayIdxT     victimWay,
  output logic                 victimDirty,
  output cachePkg::tagT        victimTag,
  output cachePkg::lineT       victimLine,
  output cachePkg::wordT       readData,
  output logic                 dirtyAtFlush
);

  cachePkg::wayIdxT    lruWay [`CACHE_SETS];  // Least recently used way per set
  cachePkg::wayIdxT    freeWay;
  logic                anyFree;
  cachePkg::wayStatusT hitStatus;
  cachePkg::wayStatusT victimStatus;

  ////////////////////////////////////////////////////////////////////////////
  // Hit and free way search
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit     = 1'b0;
    hitWay  = '0;
    anyFree = 1'b0;
    freeWay = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin  // Lowest way wins
      if (wayStatus[w].hit) begin
        hit    = 1'b1;
        hitWay = cachePkg::wayIdxT'(w);
      end
      if (!wayStatus[w].valid) begin
        anyFree = 1'b1;
        freeWay = cachePkg::wayIdxT'(w);
      end
    end
  end

  // Hit way selects itself, so a flush sees the counter way here too
  assign victimWay = hit     ? hitWay
                   : anyFree ? freeWay
                   : lruWay[setIdx];

  assign hitStatus    = wayStatus[hitWay];
  assign victimStatus = wayStatus[victimWay];

  assign readData     = hitStatus.line[offset*`WORD_BITS +: `WORD_BITS];
  assign victimTag    = victimStatus.tag;
  assign victimLine   = victimStatus.line;
  assign victimDirty  = victimStatus.valid & victimStatus.dirty;
  assign dirtyAtFlush = hit & hitStatus.valid & hitStatus.dirty;  // Invalid lines never flushed

  ////////////////////////////////////////////////////////////////////////////
  // LRU bits
  ////////////////////////////////////////////////////////////////////////////

  // Accessed way is the victim way: the hit way on a hit, the filled way at write line
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        lruWay[s] <= '0;
      end
    end else if (lruUpdate) begin
      lruWay[setIdx] <= ~victimWay;  // Other way is now oldest
    end
  end

endmodule
